/* tmu_pkg.sv */
// fixed-point widths, coordinate, position, fraction and pixel types, fetch FSM states.
package tmu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int FRAC_W = 6; // fraction bits of a texture coordinate.
	localparam int INT_W = 11; // integer bits, enough for a 2048 texel wide texture.
	localparam int COORD_W = INT_W + FRAC_W;
	localparam int POS_W = 11; // destination positions and line pitches.
	localparam int PIX_W = 16; // one RGB565 pixel per 16-bit word.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [COORD_W-1:0] coord_t; // 11.6 unsigned fixed point.
	typedef logic [POS_W-1:0] pos_t;
	typedef logic [FRAC_W-1:0] frac_t; // weight of the right or lower texel, out of 64.
	typedef logic [PIX_W-1:0] pixel_t; // red in 15:11, green in 10:5, blue in 4:0.

	// the fetch sequencer issues one texture read per state from A to D.
	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_A,
		FETCH_B,
		FETCH_C,
		FETCH_D,
		FETCH_OUT
	} fetch_state_t;

endpackage

/* tmu_if.sv */
// point interface from the scanner and address interface from the address generator.
`timescale 1ns/1ps

// one destination point with its texture coordinate.
interface tmu_point_if;
	logic stb; // point is valid, held until ack.
	logic ack; // sink can take a point.
	tmu_pkg::pos_t dx;
	tmu_pkg::pos_t dy;
	tmu_pkg::coord_t tx;
	tmu_pkg::coord_t ty;

	modport src (output stb, output dx, output dy, output tx, output ty, input ack);
	modport dst (input stb, input dx, input dy, input tx, input ty, output ack);
endinterface

// destination word address, the four texel addresses and the blend fractions.
interface tmu_adr_if #(
	parameter int adr_w = 14
);
	logic stb;
	logic ack;
	logic [adr_w-1:0] dadr; // destination word address.
	logic [adr_w-1:0] tadra; // upper left texel.
	logic [adr_w-1:0] tadrb; // upper right texel.
	logic [adr_w-1:0] tadrc; // lower left texel.
	logic [adr_w-1:0] tadrd; // lower right texel.
	tmu_pkg::frac_t x_frac;
	tmu_pkg::frac_t y_frac;

	modport src (
		output stb, output dadr, output tadra, output tadrb, output tadrc, output tadrd,
		output x_frac, output y_frac, input ack
	);
	modport dst (
		input stb, input dadr, input tadra, input tadrb, input tadrc, input tadrd,
		input x_frac, input y_frac, output ack
	);
endinterface

/* tmu_scan.sv */
// destination rectangle walker that emits one point per accepted handshake.
`timescale 1ns/1ps

module tmu_scan (
	input logic sys_clk,
	input logic sys_rst,
	input logic start_i, // only pulsed by the top level while the pipeline is idle.
	input tmu_pkg::pos_t dst_x0_i,
	input tmu_pkg::pos_t dst_y0_i,
	input tmu_pkg::pos_t width_i,
	input tmu_pkg::pos_t height_i,
	input tmu_pkg::coord_t tx0_i,
	input tmu_pkg::coord_t ty0_i,
	input tmu_pkg::coord_t dtx_i,
	input tmu_pkg::coord_t dty_i,
	output logic busy_o,
	tmu_point_if.src point_o
);

	logic active; // a point is on offer.
	logic step; // the current point is taken.
	logic row_end;
	tmu_pkg::pos_t col_left, row_left, col_last;
	tmu_pkg::pos_t x0_r, x_r, y_r;
	tmu_pkg::coord_t tx0_r, tx_r, ty_r, dtx_r, dty_r;

	assign step = point_o.stb & point_o.ack;
	assign row_end = (col_left == '0);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			active <= 1'b0;
			col_left <= '0;
			row_left <= '0;
			col_last <= '0;
		end else if (start_i) begin
			active <= (width_i != '0) && (height_i != '0); // an empty rectangle does nothing.
			col_last <= width_i - 1'b1;
			col_left <= width_i - 1'b1;
			row_left <= height_i - 1'b1;
		end else if (step) begin
			if (row_end) begin
				col_left <= col_last; // wrap to the first column.
				row_left <= row_left - 1'b1;
				if (row_left == '0)
					active <= 1'b0; // that was the last point of the last row.
			end else begin
				col_left <= col_left - 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// coordinates
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (start_i) begin
			x0_r <= dst_x0_i;
			tx0_r <= tx0_i; // kept to rewind tx at every new row.
			dtx_r <= dtx_i;
			dty_r <= dty_i;
			x_r <= dst_x0_i;
			y_r <= dst_y0_i;
			tx_r <= tx0_i;
			ty_r <= ty0_i;
		end else if (step) begin
			if (row_end) begin
				x_r <= x0_r;
				tx_r <= tx0_r;
				y_r <= y_r + 1'b1;
				ty_r <= ty_r + dty_r; // one vertical texture step per row.
			end else begin
				x_r <= x_r + 1'b1;
				tx_r <= tx_r + dtx_r;
			end
		end
	end

	assign point_o.stb = active;
	assign point_o.dx = x_r;
	assign point_o.dy = y_r;
	assign point_o.tx = tx_r;
	assign point_o.ty = ty_r;
	assign busy_o = active;

	// an offered point must stay on offer until the address generator takes it.
	a_stb_held: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		point_o.stb && !point_o.ack |=> point_o.stb
	);

endmodule

/* tmu_adrgen.sv */
// three stage address generator for the destination word and the four texel words.
`timescale 1ns/1ps

module tmu_adrgen #(
	parameter int adr_w = 14
) (
	input logic sys_clk,
	input logic sys_rst,
	output logic busy_o,
	tmu_point_if.dst point_i,
	input logic [adr_w-1:0] dst_fbuf_i, // in 16-bit words.
	input tmu_pkg::pos_t dst_hres_i,
	input logic [adr_w-1:0] tex_fbuf_i, // in 16-bit words.
	input tmu_pkg::pos_t tex_hres_i,
	tmu_adr_if.src adr_o
);

	// one enable moves all three stages together, so a held output freezes the whole pipe.
	logic pipe_en;

	logic valid_1, valid_2, valid_3;
	logic [adr_w-1:0] dadr_1, dadr_2, dadr_3;
	logic [adr_w-1:0] tadra_1, tadra_2, tadra_3;
	logic [adr_w-1:0] tadrb_3, tadrc_3, tadrd_3;
	tmu_pkg::frac_t x_frac_1, x_frac_2, x_frac_3;
	tmu_pkg::frac_t y_frac_1, y_frac_2, y_frac_3;

	assign pipe_en = ~valid_3 | adr_o.ack;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// valid bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_1 <= 1'b0;
			valid_2 <= 1'b0;
			valid_3 <= 1'b0;
		end else if (pipe_en) begin
			valid_1 <= point_i.stb; // input ack equals pipe_en, so stb means taken.
			valid_2 <= valid_1;
			valid_3 <= valid_2;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (pipe_en) begin
			// stage 1 holds both multipliers.
			dadr_1 <= dst_fbuf_i + dst_hres_i * point_i.dy + point_i.dx;
			tadra_1 <= tex_fbuf_i
				+ tex_hres_i * point_i.ty[tmu_pkg::COORD_W-1:tmu_pkg::FRAC_W]
				+ point_i.tx[tmu_pkg::COORD_W-1:tmu_pkg::FRAC_W];
			x_frac_1 <= point_i.tx[tmu_pkg::FRAC_W-1:0];
			y_frac_1 <= point_i.ty[tmu_pkg::FRAC_W-1:0];

			// stage 2 gives synthesis room to retime the multipliers.
			dadr_2 <= dadr_1;
			tadra_2 <= tadra_1;
			x_frac_2 <= x_frac_1;
			y_frac_2 <= y_frac_1;

			// stage 3 derives the right and lower neighbours.
			dadr_3 <= dadr_2;
			tadra_3 <= tadra_2;
			tadrb_3 <= tadra_2 + 1'b1;
			tadrc_3 <= tadra_2 + tex_hres_i;
			tadrd_3 <= tadra_2 + tex_hres_i + 1'b1;
			x_frac_3 <= x_frac_2;
			y_frac_3 <= y_frac_2;
		end
	end

	assign point_i.ack = pipe_en;
	assign adr_o.stb = valid_3;
	assign adr_o.dadr = dadr_3;
	assign adr_o.tadra = tadra_3;
	assign adr_o.tadrb = tadrb_3;
	assign adr_o.tadrc = tadrc_3;
	assign adr_o.tadrd = tadrd_3;
	assign adr_o.x_frac = x_frac_3;
	assign adr_o.y_frac = y_frac_3;
	assign busy_o = valid_1 | valid_2 | valid_3;

	// the fetch stage may hold off for several cycles; the offer must not change meanwhile.
	a_out_stable: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		adr_o.stb && !adr_o.ack |=> adr_o.stb && $stable(adr_o.dadr)
			&& $stable(adr_o.tadra) && $stable(adr_o.tadrb) && $stable(adr_o.tadrc)
			&& $stable(adr_o.tadrd) && $stable(adr_o.x_frac) && $stable(adr_o.y_frac)
	);

endmodule

/* tmu_texfetch.sv */
// on-chip texture memory with load port and the four-read texel fetch sequencer.
`timescale 1ns/1ps

module tmu_texfetch #(
	parameter int adr_w = 14
) (
	input logic sys_clk,
	input logic sys_rst,
	input logic tex_we_i,
	input logic [adr_w-1:0] tex_adr_i,
	input tmu_pkg::pixel_t tex_dat_i,
	tmu_adr_if.dst adr_i,
	output logic busy_o,
	output logic stb_o,
	input logic ack_i,
	output logic [adr_w-1:0] dadr_o,
	output tmu_pkg::pixel_t tex_a_o,
	output tmu_pkg::pixel_t tex_b_o,
	output tmu_pkg::pixel_t tex_c_o,
	output tmu_pkg::pixel_t tex_d_o,
	output tmu_pkg::frac_t x_frac_o,
	output tmu_pkg::frac_t y_frac_o
);

	tmu_pkg::pixel_t mem [2**adr_w];
	tmu_pkg::pixel_t rd_dat; // one cycle behind rd_adr.
	logic [adr_w-1:0] rd_adr;
	logic mem_we, take;

	tmu_pkg::fetch_state_t state;
	logic [adr_w-1:0] dadr_r, tadrb_r, tadrc_r, tadrd_r;
	tmu_pkg::pixel_t tex_a_r, tex_b_r, tex_c_r, tex_d_r;
	tmu_pkg::frac_t x_frac_r, y_frac_r;

	// loads win over a new point while the sequencer is idle.
	assign mem_we = tex_we_i & (state == tmu_pkg::FETCH_IDLE);
	assign adr_i.ack = (state == tmu_pkg::FETCH_IDLE) & ~tex_we_i;
	assign take = adr_i.stb & adr_i.ack;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// texture memory
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// texel A is read straight from the interface on the accepting edge. B to D follow.
	always_comb begin
		case (state)
			tmu_pkg::FETCH_A: rd_adr = tadrb_r;
			tmu_pkg::FETCH_B: rd_adr = tadrc_r;
			tmu_pkg::FETCH_C: rd_adr = tadrd_r;
			default: rd_adr = adr_i.tadra;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (mem_we)
			mem[tex_adr_i] <= tex_dat_i;
		rd_dat <= mem[rd_adr];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::FETCH_IDLE;
		end else begin
			case (state)
				tmu_pkg::FETCH_IDLE: if (take) state <= tmu_pkg::FETCH_A;
				tmu_pkg::FETCH_A: state <= tmu_pkg::FETCH_B;
				tmu_pkg::FETCH_B: state <= tmu_pkg::FETCH_C;
				tmu_pkg::FETCH_C: state <= tmu_pkg::FETCH_D;
				tmu_pkg::FETCH_D: state <= tmu_pkg::FETCH_OUT;
				tmu_pkg::FETCH_OUT: if (ack_i) state <= tmu_pkg::FETCH_IDLE;
				default: state <= tmu_pkg::FETCH_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			dadr_r <= adr_i.dadr;
			tadrb_r <= adr_i.tadrb;
			tadrc_r <= adr_i.tadrc;
			tadrd_r <= adr_i.tadrd;
			x_frac_r <= adr_i.x_frac;
			y_frac_r <= adr_i.y_frac;
		end
		// each state stores the texel requested one cycle earlier.
		case (state)
			tmu_pkg::FETCH_A: tex_a_r <= rd_dat;
			tmu_pkg::FETCH_B: tex_b_r <= rd_dat;
			tmu_pkg::FETCH_C: tex_c_r <= rd_dat;
			tmu_pkg::FETCH_D: tex_d_r <= rd_dat;
			default: ;
		endcase
	end

	assign stb_o = (state == tmu_pkg::FETCH_OUT);
	assign busy_o = (state != tmu_pkg::FETCH_IDLE);
	assign dadr_o = dadr_r;
	assign tex_a_o = tex_a_r;
	assign tex_b_o = tex_b_r;
	assign tex_c_o = tex_c_r;
	assign tex_d_o = tex_d_r;
	assign x_frac_o = x_frac_r;
	assign y_frac_o = y_frac_r;

	// the texture has to be loaded before a job, never while points are in flight.
	a_load_idle: assert property (
		@(posedge sys_clk) disable iff (sys_rst)
		tex_we_i |-> state == tmu_pkg::FETCH_IDLE
	);

endmodule

/* tmu_blend.sv */
// bilinear RGB565 blend of four texels with a registered pixel output.
`timescale 1ns/1ps

module tmu_blend #(
	parameter int adr_w = 14
) (
	input logic sys_clk,
	input logic sys_rst,
	output logic busy_o,
	input logic stb_i,
	output logic ack_o,
	input logic [adr_w-1:0] dadr_i,
	input tmu_pkg::pixel_t tex_a_i,
	input tmu_pkg::pixel_t tex_b_i,
	input tmu_pkg::pixel_t tex_c_i,
	input tmu_pkg::pixel_t tex_d_i,
	input tmu_pkg::frac_t x_frac_i,
	input tmu_pkg::frac_t y_frac_i,
	output logic pix_stb_o,
	input logic pix_ack_i,
	output logic [adr_w-1:0] pix_adr_o,
	output tmu_pkg::pixel_t pix_dat_o
);

	localparam int W_W = 2 * tmu_pkg::FRAC_W + 1; // a weight reaches 64*64.

	// weighted sum of one channel, scaled back by 64*64 with truncation.
	function automatic logic [5:0] mix(
		input logic [5:0] ca, input logic [5:0] cb, input logic [5:0] cc, input logic [5:0] cd,
		input logic [W_W-1:0] wa, input logic [W_W-1:0] wb,
		input logic [W_W-1:0] wc, input logic [W_W-1:0] wd
	);
		logic [W_W+5:0] sum;
		sum = ca * wa + cb * wb + cc * wc + cd * wd;
		return 6'(sum >> (2 * tmu_pkg::FRAC_W));
	endfunction

	logic [tmu_pkg::FRAC_W:0] xi, yi; // 64 minus the fraction.
	logic [W_W-1:0] wa, wb, wc, wd;
	logic [5:0] r, g, b;
	logic valid;
	logic [adr_w-1:0] adr_r;
	tmu_pkg::pixel_t dat_r;

	assign xi = (1 << tmu_pkg::FRAC_W) - x_frac_i;
	assign yi = (1 << tmu_pkg::FRAC_W) - y_frac_i;
	assign wa = xi * yi;
	assign wb = x_frac_i * yi;
	assign wc = xi * y_frac_i;
	assign wd = x_frac_i * y_frac_i; // the four weights always add up to 4096.

	// red and blue are widened to six bits; their result still fits in five.
	assign r = mix({1'b0, tex_a_i[15:11]}, {1'b0, tex_b_i[15:11]}, {1'b0, tex_c_i[15:11]},
		{1'b0, tex_d_i[15:11]}, wa, wb, wc, wd);
	assign g = mix(tex_a_i[10:5], tex_b_i[10:5], tex_c_i[10:5], tex_d_i[10:5], wa, wb, wc, wd);
	assign b = mix({1'b0, tex_a_i[4:0]}, {1'b0, tex_b_i[4:0]}, {1'b0, tex_c_i[4:0]},
		{1'b0, tex_d_i[4:0]}, wa, wb, wc, wd);

	assign ack_o = ~valid | pix_ack_i;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= 1'b0;
		else if (ack_o)
			valid <= stb_i; // refill or drain in the same cycle.
	end

	always_ff @(posedge sys_clk) begin
		if (stb_i && ack_o) begin
			adr_r <= dadr_i;
			dat_r <= {r[4:0], g, b[4:0]};
		end
	end

	assign pix_stb_o = valid;
	assign pix_adr_o = adr_r;
	assign pix_dat_o = dat_r;
	assign busy_o = valid;

endmodule

/* tmu_top.sv */
// top level of the texture mapping pipeline with job start gating and the busy flag.
`timescale 1ns/1ps

module tmu_top #(
	parameter int adr_w = 14
) (
	input logic sys_clk,
	input logic sys_rst,

	// job parameters, sampled on an accepted start.
	input logic start_i,
	input logic [adr_w-1:0] dst_fbuf_i,
	input tmu_pkg::pos_t dst_hres_i,
	input tmu_pkg::pos_t dst_x0_i,
	input tmu_pkg::pos_t dst_y0_i,
	input tmu_pkg::pos_t width_i,
	input tmu_pkg::pos_t height_i,
	input logic [adr_w-1:0] tex_fbuf_i,
	input tmu_pkg::pos_t tex_hres_i,
	input tmu_pkg::coord_t tx0_i,
	input tmu_pkg::coord_t ty0_i,
	input tmu_pkg::coord_t dtx_i,
	input tmu_pkg::coord_t dty_i,

	// texture load port.
	input logic tex_we_i,
	input logic [adr_w-1:0] tex_adr_i,
	input tmu_pkg::pixel_t tex_dat_i,

	// finished pixels.
	output logic pix_stb_o,
	input logic pix_ack_i,
	output logic [adr_w-1:0] pix_adr_o,
	output tmu_pkg::pixel_t pix_dat_o,

	output logic busy_o
);

	logic scan_busy, adrgen_busy, fetch_busy, blend_busy;
	logic scan_start;
	logic tf_stb, tf_ack;
	logic [adr_w-1:0] tf_dadr;
	tmu_pkg::pixel_t tf_a, tf_b, tf_c, tf_d;
	tmu_pkg::frac_t tf_x_frac, tf_y_frac;

	tmu_point_if point ();
	tmu_adr_if #(.adr_w(adr_w)) adr ();

	assign scan_start = start_i & ~busy_o; // a start during a job is ignored.
	assign busy_o = scan_busy | adrgen_busy | fetch_busy | blend_busy;

	tmu_scan i_scan (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .start_i(scan_start),
		.dst_x0_i(dst_x0_i), .dst_y0_i(dst_y0_i), .width_i(width_i), .height_i(height_i),
		.tx0_i(tx0_i), .ty0_i(ty0_i), .dtx_i(dtx_i), .dty_i(dty_i),
		.busy_o(scan_busy), .point_o(point)
	);

	tmu_adrgen #(.adr_w(adr_w)) i_adrgen (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .busy_o(adrgen_busy), .point_i(point),
		.dst_fbuf_i(dst_fbuf_i), .dst_hres_i(dst_hres_i),
		.tex_fbuf_i(tex_fbuf_i), .tex_hres_i(tex_hres_i), .adr_o(adr)
	);

	tmu_texfetch #(.adr_w(adr_w)) i_texfetch (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.tex_we_i(tex_we_i), .tex_adr_i(tex_adr_i), .tex_dat_i(tex_dat_i),
		.adr_i(adr), .busy_o(fetch_busy), .stb_o(tf_stb), .ack_i(tf_ack), .dadr_o(tf_dadr),
		.tex_a_o(tf_a), .tex_b_o(tf_b), .tex_c_o(tf_c), .tex_d_o(tf_d),
		.x_frac_o(tf_x_frac), .y_frac_o(tf_y_frac)
	);

	tmu_blend #(.adr_w(adr_w)) i_blend (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .busy_o(blend_busy),
		.stb_i(tf_stb), .ack_o(tf_ack), .dadr_i(tf_dadr),
		.tex_a_i(tf_a), .tex_b_i(tf_b), .tex_c_i(tf_c), .tex_d_i(tf_d),
		.x_frac_i(tf_x_frac), .y_frac_i(tf_y_frac),
		.pix_stb_o(pix_stb_o), .pix_ack_i(pix_ack_i),
		.pix_adr_o(pix_adr_o), .pix_dat_o(pix_dat_o)
	);

endmodule

/* tb_clkgen.sv */
// testbench clock and synchronous reset generator.
`timescale 1ns/1ps

module tb_clkgen #(
	parameter real period = 20.0, // clock period in ns.
	parameter int rst_cycles = 16
) (
	output logic sys_clk_o,
	output logic sys_rst_o
);

	initial begin
		sys_clk_o = 1'b0;
		forever #(period / 2.0) sys_clk_o = ~sys_clk_o;
	end

	initial begin
		sys_rst_o = 1'b1; // held over the first rising edges.
		repeat (rst_cycles) @(posedge sys_clk_o);
		sys_rst_o <= 1'b0;
	end

endmodule

/* tb_tmu.sv */
// directed tests of the texture mapping pipeline, LFSR, reference model and compare tasks.
`timescale 1ns/1ps

module tb_tmu;

	localparam int ADR_W = 14;
	localparam int TEX_BASE = 'h200; // the texture holds 12 lines of 16 words.
	localparam int TEX_HRES = 16;
	localparam int TEX_WORDS = TEX_HRES * 12;
	localparam int WAIT_LIMIT = 2000; // cycles allowed for any single wait.

	logic sys_clk, sys_rst;
	logic start_i, tex_we_i, pix_ack_i, pix_stb_o, busy_o;
	logic [ADR_W-1:0] dst_fbuf_i, tex_fbuf_i, tex_adr_i, pix_adr_o;
	tmu_pkg::pos_t dst_hres_i, dst_x0_i, dst_y0_i, width_i, height_i, tex_hres_i;
	tmu_pkg::coord_t tx0_i, ty0_i, dtx_i, dty_i;
	tmu_pkg::pixel_t tex_dat_i, pix_dat_o;

	logic [31:0] lfsr = 32'he08c2666;
	tmu_pkg::pixel_t tex_mem [0:2**ADR_W-1]; // mirror of what was loaded.
	logic [ADR_W-1:0] exp_adr[$], got_adr[$];
	tmu_pkg::pixel_t exp_dat[$], got_dat[$];

	tb_clkgen #(.period(20.0), .rst_cycles(16)) i_clkgen (
		.sys_clk_o(sys_clk), .sys_rst_o(sys_rst)
	);

	tmu_top #(.adr_w(ADR_W)) i_dut (.*);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// galois LFSR with taps for x^32 + x^22 + x^2 + x + 1 steps once per bit.
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return val;
	endfunction

	// odd multiplier keeps every 14-bit address on its own texel value.
	function automatic tmu_pkg::pixel_t fill_word(input logic [ADR_W-1:0] adr);
		return tmu_pkg::pixel_t'(32'(adr) * 32'h9e37 + 32'h1234);
	endfunction

	// bilinear filter of each channel with weights out of 64 per axis.
	function automatic tmu_pkg::pixel_t blend_ref(input tmu_pkg::pixel_t a, b, c, d,
		input int fx, fy);
		int w0, w1, w2, w3, sh, mask, acc;
		tmu_pkg::pixel_t res;
		w0 = (64 - fx) * (64 - fy);
		w1 = fx * (64 - fy);
		w2 = (64 - fx) * fy;
		w3 = fx * fy;
		res = '0;
		for (int ch = 0; ch < 3; ch++) begin
			sh = (ch == 0) ? 11 : (ch == 1) ? 5 : 0; // red, green, blue.
			mask = (ch == 1) ? 63 : 31;
			acc = ((a >> sh) & mask) * w0 + ((b >> sh) & mask) * w1
				+ ((c >> sh) & mask) * w2 + ((d >> sh) & mask) * w3;
			res = res | tmu_pkg::pixel_t'(((acc >> 12) & mask) << sh);
		end
		return res;
	endfunction

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "stopped at the first error.");
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic check_pixel(input string what, input tmu_pkg::pixel_t exp, got);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_adr(input string what, input logic [ADR_W-1:0] exp, got);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %h got %h", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic check_flag(input string what, input bit exp, input logic got);
		if (got !== exp) begin
			$display("Fail at %0t: %s expected %b got %b", $time, what, exp, got);
			stop_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#2; // inputs change well clear of the edge.
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic load_texture(input bit random_fill);
		logic [ADR_W-1:0] adr;
		for (int i = 0; i < TEX_WORDS; i++) begin
			next_cycle();
			adr = ADR_W'(TEX_BASE + i);
			tex_we_i = 1'b1;
			tex_adr_i = adr;
			tex_dat_i = random_fill ? tmu_pkg::pixel_t'(lfsr_bits(16)) : fill_word(adr);
			tex_mem[adr] = tex_dat_i;
		end
		next_cycle();
		tex_we_i = 1'b0;
	endtask

	// rows outer, columns inner; tx rewinds each row while ty keeps stepping.
	task automatic build_model();
		int tx, ty, ta, fx, fy, mask, hr;
		mask = (1 << ADR_W) - 1;
		hr = tex_hres_i;
		exp_adr.delete();
		exp_dat.delete();
		for (int row = 0; row < height_i; row++) begin
			for (int col = 0; col < width_i; col++) begin
				tx = tx0_i + col * dtx_i;
				ty = ty0_i + row * dty_i;
				exp_adr.push_back(ADR_W'(dst_fbuf_i + (dst_y0_i + row) * dst_hres_i
					+ dst_x0_i + col));
				ta = (tex_fbuf_i + (ty >> tmu_pkg::FRAC_W) * hr + (tx >> tmu_pkg::FRAC_W)) & mask;
				fx = tx & 63;
				fy = ty & 63;
				exp_dat.push_back(blend_ref(tex_mem[ta], tex_mem[(ta + 1) & mask],
					tex_mem[(ta + hr) & mask], tex_mem[(ta + hr + 1) & mask], fx, fy));
			end
		end
	endtask

	task automatic set_job(input int w, h, input tmu_pkg::coord_t tx0, ty0, dtx, dty);
		dst_fbuf_i = ADR_W'('h1000);
		dst_hres_i = 40;
		dst_x0_i = 3;
		dst_y0_i = 2;
		width_i = w;
		height_i = h;
		tex_fbuf_i = ADR_W'(TEX_BASE);
		tex_hres_i = TEX_HRES;
		tx0_i = tx0;
		ty0_i = ty0;
		dtx_i = dtx;
		dty_i = dty;
	endtask

	// starts the job, then takes pixels until busy falls; a pixel counts when stb and ack meet.
	task automatic run_job(input bit back_pressure);
		int guard;
		bit ack, held;
		logic [ADR_W-1:0] held_adr;
		tmu_pkg::pixel_t held_dat;
		build_model();
		got_adr.delete();
		got_dat.delete();
		next_cycle();
		start_i = 1'b1;
		next_cycle();
		start_i = 1'b0;
		check_flag("busy_o after start", 1'b1, busy_o);
		guard = 0;
		held = 1'b0;
		while (busy_o) begin
			if (held) begin
				check_flag("held pix_stb_o", 1'b1, pix_stb_o);
				check_adr("held pix_adr_o", held_adr, pix_adr_o);
				check_pixel("held pix_dat_o", held_dat, pix_dat_o);
			end
			ack = back_pressure ? (lfsr_bits(1) != 0) : 1'b1;
			pix_ack_i = ack;
			if (pix_stb_o && ack) begin
				got_adr.push_back(pix_adr_o);
				got_dat.push_back(pix_dat_o);
			end
			held = pix_stb_o && !ack;
			held_adr = pix_adr_o;
			held_dat = pix_dat_o;
			guard++;
			if (guard > WAIT_LIMIT)
				abort_run("Timeout: busy_o stayed high, the job never finished.");
			next_cycle();
		end
		pix_ack_i = 1'b0;
		check_flag("pix_stb_o after job", 1'b0, pix_stb_o);
		if (got_dat.size() != exp_dat.size())
			abort_run($sformatf("The job gave %0d pixels where %0d were expected.",
				got_dat.size(), exp_dat.size()));
		for (int i = 0; i < exp_dat.size(); i++) begin
			check_adr($sformatf("address of pixel %0d", i), exp_adr[i], got_adr[i]);
			check_pixel($sformatf("value of pixel %0d", i), exp_dat[i], got_dat[i]);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic idle_after_reset();
		check_flag("busy_o after reset", 1'b0, busy_o);
		check_flag("pix_stb_o after reset", 1'b0, pix_stb_o);
	endtask

	task automatic copy_texels();
		load_texture(1'b0);
		set_job(6, 4, 2 << 6, 1 << 6, 64, 64); // whole texel steps make every blend texel A.
		run_job(1'b0);
	endtask

	task automatic scale_by_half();
		load_texture(1'b1);
		set_job(8, 6, 1 << 6, 2 << 6, 32, 32);
		run_job(1'b0);
	endtask

	task automatic random_fractions();
		load_texture(1'b1);
		set_job(5, 3, lfsr_bits(8), lfsr_bits(8), lfsr_bits(7), lfsr_bits(7));
		run_job(1'b0);
	endtask

	task automatic stalled_output();
		load_texture(1'b1);
		set_job(6, 4, lfsr_bits(8), lfsr_bits(8), lfsr_bits(7), lfsr_bits(7));
		run_job(1'b1);
	endtask

	initial begin
		int guard;
		start_i = 1'b0;
		tex_we_i = 1'b0;
		tex_adr_i = '0;
		tex_dat_i = '0;
		pix_ack_i = 1'b0;
		set_job(1, 1, 0, 0, 0, 0);
		guard = 0;
		do begin
			next_cycle();
			guard++;
			if (guard > WAIT_LIMIT)
				abort_run("Timeout: reset was never released.");
		end while (sys_rst);
		idle_after_reset();
		copy_texels();
		scale_by_half();
		random_fractions();
		stalled_output();
		$display("Verification passed");
		$finish;
	end

endmodule

/* tmu_top.f */
tmu_pkg.sv
tmu_if.sv
tmu_scan.sv
tmu_adrgen.sv
tmu_texfetch.sv
tmu_blend.sv
tmu_top.sv
tb_clkgen.sv
tb_tmu.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_tmu \
	-f tmu_top.f -o tb_tmu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "compile step failed with status $status"
	exit $status
fi

./obj_dir/tb_tmu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

echo "simulation exited cleanly"
exit 0
